// File: design/csa_pkg.sv
`default_nettype none

package csa_pkg;

	// block number, round count and round-start tag
	localparam int DATA_WIDTH = 32;

	// candidate key, five bytes
	localparam int CW_IN_WIDTH = 40;

	// control word and mixed result, eight bytes
	localparam int CW_WIDTH = 64;

	localparam int BYTE_WIDTH = 8;
	localparam int CW_BYTES = CW_WIDTH / BYTE_WIDTH;

	// byte 6 of every control word built by this engine
	localparam logic [BYTE_WIDTH-1:0] ENGINE_ID = 8'd8;

	// one search job as delivered by the external FIFO
	typedef struct packed {
		logic [DATA_WIDTH-1:0]  block;
		logic [CW_IN_WIDTH-1:0] cand;
		logic [DATA_WIDTH-1:0]  times;
		logic [DATA_WIDTH-1:0]  times_start;
	} csa_job_t;

	// expanded control word, still tagged with its job
	typedef struct packed {
		csa_job_t            job;
		logic [CW_WIDTH-1:0] cw;
	} csa_word_t;

	// final word after all rounds
	typedef struct packed {
		csa_job_t            job;
		logic [CW_WIDTH-1:0] out;
	} csa_result_t;

endpackage

`default_nettype wire

// File: design/csa_job_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module csa_job_fetch (
	input  wire               clk,
	input  wire               rst_n,

	input  wire               fifo_ready_i,
	output logic              fifo_ren_o,
	input  wire csa_pkg::csa_job_t job_i,

	output logic              job_valid_o,
	output csa_pkg::csa_job_t job_o,
	input  wire               job_take_i
);

	// read issued last cycle so data is on job_i now
	logic rd_pend;

	// one read at a time and only into an empty slot
	assign fifo_ren_o = fifo_ready_i && !rd_pend && !job_valid_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pend     <= 1'b0;
			job_valid_o <= 1'b0;
		end else begin
			rd_pend <= fifo_ren_o;

			if (rd_pend) begin
				// slot is known empty here so no take can collide
				job_valid_o <= 1'b1;
			end else if (job_take_i) begin
				job_valid_o <= 1'b0;
			end
		end
	end

	// held job captured with a FIFO read latency of one
	always_ff @(posedge clk) begin
		if (rd_pend) begin
			job_o <= job_i;
		end
	end

	// never read from an empty FIFO or over a held job
	assert property (
		@(posedge clk) disable iff (!rst_n)
		fifo_ren_o |-> fifo_ready_i && !job_valid_o
	);

endmodule

`default_nettype wire

// File: design/csa_cw_builder.sv
`timescale 1ns/100ps
`default_nettype none

module csa_cw_builder (
	input  wire                clk,
	input  wire                rst_n,

	input  wire                job_valid_i,
	input  wire csa_pkg::csa_job_t job_i,
	output logic               job_take_o,

	output logic               word_valid_o,
	output csa_pkg::csa_word_t word_o,
	input  wire                word_take_i
);

	// candidate plus engine id with both DVB checksum bytes
	function automatic logic [csa_pkg::CW_WIDTH-1:0] build_cw(
		input logic [csa_pkg::CW_IN_WIDTH-1:0] cand
	);
		logic [csa_pkg::BYTE_WIDTH-1:0] lo_sum;
		logic [csa_pkg::BYTE_WIDTH-1:0] hi_sum;

		// byte 3 covers bytes 0..2
		lo_sum = cand[7:0] + cand[15:8] + cand[23:16];
		// byte 7 covers bytes 4..6
		hi_sum = cand[31:24] + cand[39:32] + csa_pkg::ENGINE_ID;

		return {hi_sum, csa_pkg::ENGINE_ID, cand[39:24], lo_sum, cand[23:0]};
	endfunction

	// slot free now or freed by the round engine this cycle
	assign job_take_o = job_valid_i && (!word_valid_o || word_take_i);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			word_valid_o <= 1'b0;
		end else if (job_take_o) begin
			word_valid_o <= 1'b1;
		end else if (word_take_i) begin
			word_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (job_take_o) begin
			word_o.job <= job_i;
			word_o.cw  <= build_cw(job_i.cand);
		end
	end

	// held word stays put until the engine takes it
	assert property (
		@(posedge clk) disable iff (!rst_n)
		word_valid_o && !word_take_i |=> $stable(word_o)
	);

endmodule

`default_nettype wire

// File: design/csa_round_engine.sv
`timescale 1ns/100ps
`default_nettype none

module csa_round_engine (
	input  wire                  clk,
	input  wire                  rst_n,

	input  wire                  word_valid_i,
	input  wire csa_pkg::csa_word_t word_i,
	output logic                 word_take_o,

	output logic                 ready_o,
	output csa_pkg::csa_result_t result_o
);

	logic                           busy;
	logic [csa_pkg::DATA_WIDTH-1:0] round_cnt;
	logic                           last_round;

	// working copy of the job and word while rounds run
	csa_pkg::csa_job_t              job_q;
	logic [csa_pkg::CW_WIDTH-1:0]   work;

	logic [csa_pkg::BYTE_WIDTH-1:0] round_tag;
	logic [csa_pkg::CW_WIDTH-1:0]   first_word;
	logic [csa_pkg::CW_WIDTH-1:0]   next_word;

	// one mixing round rotates left by a byte and folds the old byte sum
	// and the round tag into the new byte 0
	function automatic logic [csa_pkg::CW_WIDTH-1:0] mix_round(
		input logic [csa_pkg::CW_WIDTH-1:0]   w,
		input logic [csa_pkg::BYTE_WIDTH-1:0] tag
	);
		logic [csa_pkg::BYTE_WIDTH-1:0] sum;
		logic [csa_pkg::CW_WIDTH-1:0]   rot;

		sum = '0;
		for (int i = 0; i < csa_pkg::CW_BYTES; i++) begin
			sum = sum + w[i*csa_pkg::BYTE_WIDTH +: csa_pkg::BYTE_WIDTH];
		end

		rot = {w[csa_pkg::CW_WIDTH-csa_pkg::BYTE_WIDTH-1:0],
			w[csa_pkg::CW_WIDTH-1 -: csa_pkg::BYTE_WIDTH]};
		rot[csa_pkg::BYTE_WIDTH-1:0] = rot[csa_pkg::BYTE_WIDTH-1:0] ^ sum ^ tag;
		return rot;
	endfunction

	// idle also excludes the cycle that presents a result
	assign word_take_o = word_valid_i && !busy && !ready_o;

	// round 0 runs on the take edge itself
	assign first_word = mix_round(word_i.cw, word_i.job.times_start[7:0]);

	// later rounds use k = round_cnt
	assign round_tag  = job_q.times_start[7:0] + round_cnt[7:0];
	assign next_word  = mix_round(work, round_tag);
	assign last_round = (round_cnt == job_q.times - 1'b1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			round_cnt <= '0;
			ready_o   <= 1'b0;
			result_o  <= '0;
		end else begin
			ready_o <= 1'b0;

			if (word_take_o) begin
				round_cnt <= 1;
				if (word_i.job.times == '0) begin
					// no rounds so the plain control word goes back
					result_o.job <= word_i.job;
					result_o.out <= word_i.cw;
					ready_o      <= 1'b1;
				end else if (word_i.job.times == 1) begin
					result_o.job <= word_i.job;
					result_o.out <= first_word;
					ready_o      <= 1'b1;
				end else begin
					busy <= 1'b1;
				end
			end else if (busy) begin
				round_cnt <= round_cnt + 1'b1;
				if (last_round) begin
					result_o.job <= job_q;
					result_o.out <= next_word;
					ready_o      <= 1'b1;
					busy         <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_take_o) begin
			job_q <= word_i.job;
			work  <= first_word;
		end else if (busy) begin
			work <= next_word;
		end
	end

	// ready is a strobe and never a level
	assert property (
		@(posedge clk) disable iff (!rst_n)
		ready_o |=> !ready_o
	);

	// a taken word occupies the engine at least through the next cycle
	assert property (
		@(posedge clk) disable iff (!rst_n)
		word_take_o |=> !word_take_o
	);

endmodule

`default_nettype wire

// File: design/csa_calc_logic.sv
`timescale 1ns/100ps
`default_nettype none

module csa_calc_logic (
	input  wire                  clk,
	input  wire                  rst_n,

	// external job FIFO
	input  wire                  fifo_ready_i,
	output logic                 fifo_ren_o,
	input  wire csa_pkg::csa_job_t job_i,

	// result strobe and data
	output logic                 ready_o,
	output csa_pkg::csa_result_t result_o
);

	// fetch to builder
	logic               job_valid;
	logic               job_take;
	csa_pkg::csa_job_t  job;

	// builder to round engine
	logic               word_valid;
	logic               word_take;
	csa_pkg::csa_word_t word;

	csa_job_fetch fetch0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_ready_i (fifo_ready_i),
		.fifo_ren_o   (fifo_ren_o),
		.job_i        (job_i),
		.job_valid_o  (job_valid),
		.job_o        (job),
		.job_take_i   (job_take)
	);

	csa_cw_builder builder0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.job_valid_i  (job_valid),
		.job_i        (job),
		.job_take_o   (job_take),
		.word_valid_o (word_valid),
		.word_o       (word),
		.word_take_i  (word_take)
	);

	csa_round_engine engine0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.word_valid_i (word_valid),
		.word_i       (word),
		.word_take_o  (word_take),
		.ready_o      (ready_o),
		.result_o     (result_o)
	);

endmodule

`default_nettype wire

// File: tests/csa_calc_logic_tests.svh
`ifndef CSA_CALC_LOGIC_TESTS_SVH
`define CSA_CALC_LOGIC_TESTS_SVH
`default_nettype none

task automatic next_cycle();
	@(posedge clk);
	#2;
endtask

task automatic push_job(input csa_pkg::csa_job_t j);
	fifo_q.push_back(j);
	exp_q.push_back(model_result(j));
endtask

task automatic random_job(input logic [31:0] block, output csa_pkg::csa_job_t j);
	logic [31:0] r0;
	logic [31:0] r1;
	logic [31:0] r2;

	r0 = $random(seed);
	r1 = $random(seed);
	r2 = $random(seed);
	j.block = block;
	j.cand = {r1[7:0], r0};
	j.times = {24'd0, r1[15:8]} % (MAX_TIMES + 1);
	j.times_start = r2;
endtask

task automatic wait_results(input int max_cycles);
	int waited;

	waited = 0;
	while (exp_q.size() != 0 && waited < max_cycles) begin
		next_cycle();
		waited++;
	end
	if (exp_q.size() != 0) begin
		abort_run($sformatf("%0d results missing after %0d cycles", exp_q.size(), waited));
	end
endtask

task automatic reset_state_holds();
	repeat (20) begin
		@(negedge clk);
		check_bit("fifo_ren_o", fifo_ren_o, 1'b0);
		check_bit("ready_o", ready_o, 1'b0);
		check_job(result_o.job, '0);
		check_word("result_o.out", result_o.out, '0);
	end
	next_cycle();
endtask

task automatic zero_rounds_return_cw();
	push_job('{block: 32'd2, cand: 40'h12_3456_789a, times: 32'd0, times_start: 32'h11});
	wait_results(20);
	// sums 0x68 and 0x4e, engine id 0x08
	check_word("result_o.out", last_result.out, 64'h4e08_1234_6856_789a);
endtask

task automatic latency_single_job();
	push_job('{block: 32'd3, cand: 40'hfe_dcba_9876, times: 32'd5, times_start: 32'h40});
	wait_results(30);
	check_cycles("fifo_ren_o to ready_o", ready_cycle - ren_cycle, 8);
endtask

task automatic start_tag_changes_result();
	push_job('{block: 32'd4, cand: 40'ha5_5ac3_3c0f, times: 32'd7, times_start: 32'h00});
	push_job('{block: 32'd5, cand: 40'ha5_5ac3_3c0f, times: 32'd7, times_start: 32'h5d});
	wait_results(60);
	if (seen_out[$] === seen_out[$-1]) begin
		abort_run("two different round-start tags gave the same result");
	end
endtask

task automatic backpressure_keeps_order();
	csa_pkg::csa_job_t j;

	for (int i = 0; i < 10; i++) begin
		random_job(32'd100 + i, j);
		push_job(j);
	end
	wait_results(10 * (MAX_TIMES + 8));
endtask

task automatic gaps_between_jobs();
	csa_pkg::csa_job_t j;
	logic [31:0]       r;
	int                gap;

	for (int i = 0; i < 8; i++) begin
		random_job(32'd200 + i, j);
		push_job(j);
		r = $random(seed);
		gap = {28'd0, r[3:0]} % (MAX_GAP + 1);
		repeat (gap) next_cycle();
	end
	wait_results(8 * (MAX_TIMES + 8));
endtask

`default_nettype wire
`endif

// File: tests/csa_calc_logic_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csa_calc_logic_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_TIMES = 40;
	localparam int MAX_GAP = 10;
	localparam int NUM_JOBS = 22;
	// every job bounded by its rounds, the pipeline and the longest gap
	localparam int WATCHDOG_CYCLES =
		RESET_CYCLES + 20 + NUM_JOBS * (MAX_TIMES + 8 + MAX_GAP) + 200;

	logic                 clk;
	logic                 rst_n;
	logic                 fifo_ready_i = 1'b0;
	logic                 fifo_ren_o;
	csa_pkg::csa_job_t    job_i = '0;
	logic                 ready_o;
	csa_pkg::csa_result_t result_o;

	csa_pkg::csa_job_t            fifo_q[$];
	csa_pkg::csa_result_t         exp_q[$];
	logic [csa_pkg::CW_WIDTH-1:0] seen_out[$];
	csa_pkg::csa_result_t         last_result;
	csa_pkg::csa_result_t         exp_res;
	logic                         ren_seen = 1'b0;
	int                           cycle = 0;
	int                           ren_cycle = 0;
	int                           ready_cycle = 0;
	int                           seed = 32'hb8c7;

	csa_calc_logic dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_ready_i (fifo_ready_i),
		.fifo_ren_o   (fifo_ren_o),
		.job_i        (job_i),
		.ready_o      (ready_o),
		.result_o     (result_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before all results came back");
	end

	// FIFO model, read latency of one
	always @(posedge clk) begin
		cycle <= cycle + 1;
		#1;
		if (ren_seen && fifo_q.size() != 0) begin
			job_i = fifo_q.pop_front();
		end
		fifo_ready_i = (fifo_q.size() != 0);
	end

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		ren_seen = rst_n && fifo_ren_o;
		if (ren_seen) begin
			ren_cycle = cycle;
			if (!fifo_ready_i) begin
				abort_run("fifo_ren_o pulsed while the FIFO was empty");
			end
		end
		if (rst_n && ready_o) begin
			ready_cycle = cycle;
			if (exp_q.size() == 0) begin
				abort_run("ready_o pulsed with no result expected");
			end else begin
				exp_res = exp_q.pop_front();
				check_job(result_o.job, exp_res.job);
				check_word("result_o.out", result_o.out, exp_res.out);
				last_result = result_o;
				seen_out.push_back(result_o.out);
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
		reset_state_holds();
		zero_rounds_return_cw();
		latency_single_job();
		start_tag_changes_result();
		backpressure_keeps_order();
		gaps_between_jobs();
		if (exp_q.size() != 0) begin
			abort_run("results still missing at the end of the run");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input logic [csa_pkg::CW_WIDTH-1:0] got,
			input logic [csa_pkg::CW_WIDTH-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_job(input csa_pkg::csa_job_t got, input csa_pkg::csa_job_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR t=%0t result_o.job: got %h expected %h",
				$time, got, exp));
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	// byte 0 is least significant, checksums at bytes 3 and 7
	function automatic csa_pkg::csa_result_t model_result(input csa_pkg::csa_job_t j);
		logic [7:0]           b [8];
		logic [7:0]           prev [8];
		logic [7:0]           sum;
		csa_pkg::csa_result_t r;

		b[0] = j.cand[7:0];
		b[1] = j.cand[15:8];
		b[2] = j.cand[23:16];
		b[3] = b[0] + b[1] + b[2];
		b[4] = j.cand[31:24];
		b[5] = j.cand[39:32];
		b[6] = csa_pkg::ENGINE_ID;
		b[7] = b[4] + b[5] + b[6];
		for (int unsigned k = 0; k < j.times; k++) begin
			prev = b;
			sum = 8'd0;
			for (int i = 0; i < 8; i++) begin
				sum = sum + prev[i];
			end
			for (int i = 1; i < 8; i++) begin
				b[i] = prev[i-1];
			end
			b[0] = prev[7] ^ sum ^ (j.times_start[7:0] + k[7:0]);
		end
		r.job = j;
		for (int i = 0; i < 8; i++) begin
			r.out[i*8 +: 8] = b[i];
		end
		return r;
	endfunction

`include "csa_calc_logic_tests.svh"

endmodule

`default_nettype wire

// File: csa_calc_logic.f
+incdir+tests
design/csa_pkg.sv
design/csa_job_fetch.sv
design/csa_cw_builder.sv
design/csa_round_engine.sv
design/csa_calc_logic.sv
tests/csa_calc_logic_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := csa_calc_logic_tb
FILELIST := csa_calc_logic.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
